//--- rtl/ecc_pkg.sv
/*
 * Shared definitions for the modular arithmetic engine
 * Word and scalar sizes, moduli, register map, command codes,
 * micro-operation word and host write bundle
 */
package ecc_pkg;

    // Sizes --------------------
    localparam int REG_SIZE   = 32;
    localparam int KEY_SIZE   = 32;
    localparam int ADDR_WIDTH = 4;
    localparam int NUM_REGS   = 2 ** ADDR_WIDTH;

    // Multiplier step counter, counts REG_SIZE down to 0
    localparam int MULT_CNT_W = $clog2(REG_SIZE + 1);

    // Sequencer op counter, two init adds then two multiplies per scalar bit
    localparam int                  OP_CNT_W    = 7;
    localparam logic [OP_CNT_W-1:0] EXP_LAST_OP = OP_CNT_W'(1 + 2 * KEY_SIZE);

    // Moduli --------------------
    // Field prime p
    localparam logic [REG_SIZE-1:0] P_PRIME = 32'hffff_fffb;
    // Group order q, odd and above 2^31 like p
    localparam logic [REG_SIZE-1:0] Q_ORDER = 32'hfffd_4c37;

    // Register map --------------------
    localparam logic [ADDR_WIDTH-1:0] R0_ADDR   = 4'd0;
    localparam logic [ADDR_WIDTH-1:0] R1_ADDR   = 4'd1;
    localparam logic [ADDR_WIDTH-1:0] R2_ADDR   = 4'd2;
    localparam logic [ADDR_WIDTH-1:0] R4_ADDR   = 4'd4;
    localparam logic [ADDR_WIDTH-1:0] R5_ADDR   = 4'd5;
    // Constant words, set by reset
    localparam logic [ADDR_WIDTH-1:0] ZERO_ADDR = 4'd14;
    localparam logic [ADDR_WIDTH-1:0] ONE_ADDR  = 4'd15;

    // Host commands
    typedef enum logic [2:0] {
        CMD_NOP   = 3'd0,
        CMD_ADD_P = 3'd1,
        CMD_SUB_P = 3'd2,
        CMD_MUL_P = 3'd3,
        CMD_EXP_P = 3'd4,
        CMD_ADD_Q = 3'd5,
        CMD_SUB_Q = 3'd6,
        CMD_MUL_Q = 3'd7
    } ecc_cmd_e;

    // Micro-operation, one 16-bit word per cycle
    typedef struct packed {
        logic                  mod_q;
        logic                  mult_en;
        logic                  add_en;
        logic                  sub;
        logic                  wea;
        logic                  web;
        logic [1:0]            spare;   // free for later ops, kept zero
        logic [ADDR_WIDTH-1:0] addra;
        logic [ADDR_WIDTH-1:0] addrb;
    } ecc_uop_t;

    // Registered host write on port B
    typedef struct packed {
        logic                  we;
        logic [ADDR_WIDTH-1:0] addr;
        logic [REG_SIZE-1:0]   data;
    } host_wr_t;

endpackage

//--- rtl/ecc_ram_tdp_file.sv
/*
 * True dual-port register file, 16 words
 * Synchronous reads on both ports, reset loads the constant words
 */
`timescale 1ns/1ps

module ecc_ram_tdp_file (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          wea_i,
    input  logic [ecc_pkg::ADDR_WIDTH-1:0] addra_i,
    input  logic [ecc_pkg::REG_SIZE-1:0]  dina_i,
    output logic [ecc_pkg::REG_SIZE-1:0]  douta_o,
    input  logic                          web_i,
    input  logic [ecc_pkg::ADDR_WIDTH-1:0] addrb_i,
    input  logic [ecc_pkg::REG_SIZE-1:0]  dinb_i,
    output logic [ecc_pkg::REG_SIZE-1:0]  doutb_o
);

    logic [ecc_pkg::REG_SIZE-1:0] mem [ecc_pkg::NUM_REGS];

    // Writes, all words zero after reset except the ONE word
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < ecc_pkg::NUM_REGS; i++) begin
                mem[i] <= '0;
            end
            mem[ecc_pkg::ONE_ADDR] <= ecc_pkg::REG_SIZE'(1);
        end else begin
            if (wea_i) begin
                mem[addra_i] <= dina_i;
            end
            if (web_i) begin
                mem[addrb_i] <= dinb_i;
            end
        end
    end

    // Reads return the old word on a same-cycle write
    always_ff @(posedge clk) begin
        douta_o <= mem[addra_i];
        doutb_o <= mem[addrb_i];
    end

    // Sequencer and host never target one word from both ports at once
    a_no_dual_write: assert property (@(posedge clk) disable iff (!reset_n)
        !(wea_i && web_i && (addra_i == addrb_i)))
        else $error("both ports write one address");

endmodule

//--- rtl/ecc_fau.sv
/*
 * Field arithmetic unit
 * Single-cycle modular add and subtract
 * Bit-serial MSB-first interleaved modular multiplier, REG_SIZE cycles
 */
`timescale 1ns/1ps

module ecc_fau (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         add_en_i,
    input  logic                         sub_i,
    input  logic                         mult_en_i,
    input  logic                         mod_q_i,
    input  logic [ecc_pkg::REG_SIZE-1:0] opa_i,
    input  logic [ecc_pkg::REG_SIZE-1:0] opb_i,
    output logic [ecc_pkg::REG_SIZE-1:0] add_res_o,
    output logic [ecc_pkg::REG_SIZE-1:0] mult_res_o,
    output logic                         mult_done_o
);

    logic [ecc_pkg::REG_SIZE-1:0]   modulus;

    // Adder
    logic [ecc_pkg::REG_SIZE:0]     add_raw;
    logic [ecc_pkg::REG_SIZE:0]     add_fix;
    logic [ecc_pkg::REG_SIZE-1:0]   add_val;

    // Multiplier state
    logic [ecc_pkg::REG_SIZE-1:0]   mul_a_r;
    logic [ecc_pkg::REG_SIZE-1:0]   mul_b_r;
    logic [ecc_pkg::REG_SIZE-1:0]   mul_m_r;
    logic [ecc_pkg::REG_SIZE-1:0]   acc_r;
    logic [ecc_pkg::MULT_CNT_W-1:0] cnt_r;
    logic                           running_r;
    logic                           done_r;

    // Multiplier step terms, two guard bits for the sign
    logic [ecc_pkg::REG_SIZE+1:0]   dbl;
    logic [ecc_pkg::REG_SIZE+1:0]   dbl_sub;
    logic [ecc_pkg::REG_SIZE+1:0]   dbl_red;
    logic [ecc_pkg::REG_SIZE+1:0]   acc_sum;
    logic [ecc_pkg::REG_SIZE+1:0]   sum_sub;
    logic [ecc_pkg::REG_SIZE-1:0]   acc_next;
    logic [ecc_pkg::REG_SIZE:0]     a_sub;
    logic [ecc_pkg::REG_SIZE-1:0]   a_red;

    assign modulus = mod_q_i ? ecc_pkg::Q_ORDER : ecc_pkg::P_PRIME;

    // Add / subtract --------------------
    always_comb begin
        if (sub_i) begin
            add_raw = {1'b0, opa_i} - {1'b0, opb_i};
            add_fix = add_raw + {1'b0, modulus};
            // Borrow out, wrap back into range
            add_val = add_raw[ecc_pkg::REG_SIZE] ? add_fix[ecc_pkg::REG_SIZE-1:0]
                                                 : add_raw[ecc_pkg::REG_SIZE-1:0];
        end else begin
            add_raw = {1'b0, opa_i} + {1'b0, opb_i};
            add_fix = add_raw - {1'b0, modulus};
            // Sum below modulus when the correction goes negative
            add_val = add_fix[ecc_pkg::REG_SIZE] ? add_raw[ecc_pkg::REG_SIZE-1:0]
                                                 : add_fix[ecc_pkg::REG_SIZE-1:0];
        end
    end

    assign add_res_o = add_en_i ? add_val : '0;

    // Multiplier --------------------
    // Operand a may exceed q, one subtraction brings it below
    assign a_sub = {1'b0, opa_i} - {1'b0, modulus};
    assign a_red = a_sub[ecc_pkg::REG_SIZE] ? opa_i : a_sub[ecc_pkg::REG_SIZE-1:0];

    // acc = 2*acc + b_msb*a, reduced after each term
    always_comb begin
        dbl      = {1'b0, acc_r, 1'b0};
        dbl_sub  = dbl - {2'b00, mul_m_r};
        dbl_red  = dbl_sub[ecc_pkg::REG_SIZE+1] ? dbl : dbl_sub;
        acc_sum  = dbl_red + (mul_b_r[ecc_pkg::REG_SIZE-1] ? {2'b00, mul_a_r} : '0);
        sum_sub  = acc_sum - {2'b00, mul_m_r};
        acc_next = sum_sub[ecc_pkg::REG_SIZE+1] ? acc_sum[ecc_pkg::REG_SIZE-1:0]
                                                : sum_sub[ecc_pkg::REG_SIZE-1:0];
    end

    // Step counter and done pulse
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            running_r <= 1'b0;
            done_r    <= 1'b0;
            cnt_r     <= '0;
        end else begin
            done_r <= 1'b0;
            if (mult_en_i) begin
                running_r <= 1'b1;
                cnt_r     <= ecc_pkg::MULT_CNT_W'(ecc_pkg::REG_SIZE);
            end else if (running_r) begin
                cnt_r <= cnt_r - 1'b1;
                // Last bit of b
                if (cnt_r == ecc_pkg::MULT_CNT_W'(1)) begin
                    running_r <= 1'b0;
                    done_r    <= 1'b1;
                end
            end
        end
    end

    // Datapath, modulus latched at start
    always_ff @(posedge clk) begin
        if (mult_en_i) begin
            mul_a_r <= a_red;
            mul_b_r <= opb_i;
            mul_m_r <= modulus;
            acc_r   <= '0;
        end else if (running_r) begin
            acc_r   <= acc_next;
            mul_b_r <= {mul_b_r[ecc_pkg::REG_SIZE-2:0], 1'b0};
        end
    end

    assign mult_res_o  = acc_r;
    assign mult_done_o = done_r;

    // Sequencer never issues adder and multiplier in one micro-op
    a_add_mult_excl: assert property (@(posedge clk) disable iff (!reset_n)
        !(add_en_i && mult_en_i))
        else $error("add and multiply in one micro-op");

    // No restart while a product is still in flight
    a_mult_no_restart: assert property (@(posedge clk) disable iff (!reset_n)
        mult_en_i |-> !running_r)
        else $error("multiplier restarted while running");

endmodule

//--- rtl/ecc_pm_ctrl.sv
/*
 * Command sequencer
 * Expands host commands into micro-operations, each as read, execute
 * and optional multiply wait, including the scalar-driven ladder
 */
`timescale 1ns/1ps

module ecc_pm_ctrl (
    input  logic              clk,
    input  logic              reset_n,
    input  ecc_pkg::ecc_cmd_e ecc_cmd_i,
    input  logic              digit_i,
    input  logic              mult_done_i,
    output ecc_pkg::ecc_uop_t uop_o,
    output logic              req_digit_o,
    output logic              busy_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD,     // operand addresses on both ports
        S_EX,     // add and write, or multiplier start
        S_MW,     // wait for product, write on port B
        S_NEXT,   // advance to next op
        S_END
    } state_e;

    // One decoded field operation
    typedef struct packed {
        logic                           mul;
        logic                           sub;
        logic                           mod_q;
        logic [ecc_pkg::ADDR_WIDTH-1:0] src_a;
        logic [ecc_pkg::ADDR_WIDTH-1:0] src_b;
        logic [ecc_pkg::ADDR_WIDTH-1:0] dst;
    } op_t;

    state_e                       state_r;
    ecc_pkg::ecc_cmd_e            cmd_r;
    logic [ecc_pkg::OP_CNT_W-1:0] op_cnt_r;
    logic                         bit_r;     // scalar bit of the current step
    logic                         last_op;
    op_t                          op;

    // Op decode --------------------
    always_comb begin
        op.mul   = 1'b0;
        op.sub   = 1'b0;
        op.mod_q = (cmd_r == ecc_pkg::CMD_ADD_Q) || (cmd_r == ecc_pkg::CMD_SUB_Q) ||
                   (cmd_r == ecc_pkg::CMD_MUL_Q);
        // Single ops, R2 := R0 op R1
        op.src_a = ecc_pkg::R0_ADDR;
        op.src_b = ecc_pkg::R1_ADDR;
        op.dst   = ecc_pkg::R2_ADDR;
        case (cmd_r)
            ecc_pkg::CMD_SUB_P, ecc_pkg::CMD_SUB_Q: op.sub = 1'b1;
            ecc_pkg::CMD_MUL_P, ecc_pkg::CMD_MUL_Q: op.mul = 1'b1;
            ecc_pkg::CMD_EXP_P: begin
                if (op_cnt_r == '0) begin
                    // R4 := 1
                    op.src_a = ecc_pkg::ONE_ADDR;
                    op.src_b = ecc_pkg::ZERO_ADDR;
                    op.dst   = ecc_pkg::R4_ADDR;
                end else if (op_cnt_r == ecc_pkg::OP_CNT_W'(1)) begin
                    // R5 := R0, reduced mod p
                    op.src_b = ecc_pkg::ZERO_ADDR;
                    op.dst   = ecc_pkg::R5_ADDR;
                end else if (!op_cnt_r[0]) begin
                    // First half, product into the register picked by the bit
                    op.mul   = 1'b1;
                    op.src_a = ecc_pkg::R4_ADDR;
                    op.src_b = ecc_pkg::R5_ADDR;
                    op.dst   = bit_r ? ecc_pkg::R4_ADDR : ecc_pkg::R5_ADDR;
                end else begin
                    // Second half squares the other register
                    op.mul   = 1'b1;
                    op.src_a = bit_r ? ecc_pkg::R5_ADDR : ecc_pkg::R4_ADDR;
                    op.src_b = op.src_a;
                    op.dst   = op.src_a;
                end
            end
            default: ;
        endcase
    end

    assign last_op = (cmd_r != ecc_pkg::CMD_EXP_P) || (op_cnt_r == ecc_pkg::EXP_LAST_OP);

    // Next digit when entering the first half of a ladder step
    assign req_digit_o = (state_r == S_NEXT) && !last_op && op_cnt_r[0];
    assign busy_o      = (state_r != S_IDLE);

    // FSM --------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_r  <= S_IDLE;
            cmd_r    <= ecc_pkg::CMD_NOP;
            op_cnt_r <= '0;
            bit_r    <= 1'b0;
        end else begin
            case (state_r)
                S_IDLE: begin
                    // Commands only accepted here
                    if (ecc_cmd_i != ecc_pkg::CMD_NOP) begin
                        cmd_r    <= ecc_cmd_i;
                        op_cnt_r <= '0;
                        state_r  <= S_RD;
                    end
                end
                S_RD: state_r <= S_EX;
                S_EX: state_r <= op.mul ? S_MW : S_NEXT;
                S_MW: begin
                    if (mult_done_i) begin
                        state_r <= S_NEXT;
                    end
                end
                S_NEXT: begin
                    if (last_op) begin
                        state_r <= S_END;
                    end else begin
                        op_cnt_r <= op_cnt_r + 1'b1;
                        if (req_digit_o) begin
                            bit_r <= digit_i;
                        end
                        state_r <= S_RD;
                    end
                end
                default: state_r <= S_IDLE;
            endcase
        end
    end

    // Micro-op word, zero outside the active states
    always_comb begin
        uop_o = '0;
        if ((state_r == S_RD) || (state_r == S_EX) || (state_r == S_MW)) begin
            uop_o.mod_q = op.mod_q;
            uop_o.addra = op.src_a;
            uop_o.addrb = op.src_b;
        end
        case (state_r)
            S_EX: begin
                if (op.mul) begin
                    uop_o.mult_en = 1'b1;
                end else begin
                    uop_o.add_en = 1'b1;
                    uop_o.sub    = op.sub;
                    uop_o.wea    = 1'b1;
                    uop_o.addra  = op.dst;
                end
            end
            S_MW: begin
                // Hold destination until the product is valid
                uop_o.addrb = op.dst;
                uop_o.web   = mult_done_i;
            end
            default: ;
        endcase
    end

    // Product only arrives while waiting for it
    a_done_in_wait: assert property (@(posedge clk) disable iff (!reset_n)
        mult_done_i |-> (state_r == S_MW))
        else $error("multiplier done outside wait state");

endmodule

//--- rtl/ecc_arith_unit.sv
/*
 * Modular arithmetic engine top level
 * Host port registers, scalar shift register, port B sharing
 * between host and sequencer, read data gating
 */
`timescale 1ns/1ps

module ecc_arith_unit (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic [2:0]                     ecc_cmd_i,
    input  logic [ecc_pkg::ADDR_WIDTH-1:0] addr_i,
    input  logic                           wr_op_sel_i,
    input  logic                           wr_en_i,
    input  logic                           rd_reg_i,
    input  logic [ecc_pkg::REG_SIZE-1:0]   data_i,
    output logic [ecc_pkg::REG_SIZE-1:0]   data_o,
    output logic                           busy_o
);

    ecc_pkg::ecc_uop_t              uop;
    ecc_pkg::host_wr_t              host_wr_r;
    logic [1:0]                     rd_pipe_r;
    logic [ecc_pkg::KEY_SIZE-1:0]   key_r;
    logic [ecc_pkg::REG_SIZE-1:0]   data_r;
    logic                           req_digit;
    logic                           busy;

    // Datapath
    logic [ecc_pkg::REG_SIZE-1:0]   douta;
    logic [ecc_pkg::REG_SIZE-1:0]   doutb;
    logic [ecc_pkg::REG_SIZE-1:0]   add_res;
    logic [ecc_pkg::REG_SIZE-1:0]   mult_res;
    logic                           mult_done;

    // Port B after the host/sequencer mux
    logic                           web;
    logic [ecc_pkg::ADDR_WIDTH-1:0] addrb;
    logic [ecc_pkg::REG_SIZE-1:0]   dinb;

    ecc_pm_ctrl ecc_pm_ctrl_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .ecc_cmd_i   (ecc_pkg::ecc_cmd_e'(ecc_cmd_i)),
        .digit_i     (key_r[ecc_pkg::KEY_SIZE-1]),
        .mult_done_i (mult_done),
        .uop_o       (uop),
        .req_digit_o (req_digit),
        .busy_o      (busy)
    );

    ecc_ram_tdp_file ecc_ram_tdp_file_i (
        .clk     (clk),
        .reset_n (reset_n),
        .wea_i   (uop.wea),
        .addra_i (uop.addra),
        .dina_i  (add_res),
        .douta_o (douta),
        .web_i   (web),
        .addrb_i (addrb),
        .dinb_i  (dinb),
        .doutb_o (doutb)
    );

    // Modulus select travels with the micro-op
    ecc_fau ecc_fau_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .add_en_i    (uop.add_en),
        .sub_i       (uop.sub),
        .mult_en_i   (uop.mult_en),
        .mod_q_i     (uop.mod_q),
        .opa_i       (douta),
        .opb_i       (doutb),
        .add_res_o   (add_res),
        .mult_res_o  (mult_res),
        .mult_done_o (mult_done)
    );

    // Host port registers --------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            host_wr_r <= '0;
            rd_pipe_r <= '0;
            key_r     <= '0;
            data_r    <= '0;
        end else begin
            host_wr_r.addr <= addr_i;
            host_wr_r.we   <= wr_en_i && !wr_op_sel_i;
            if (wr_en_i && !wr_op_sel_i) begin
                host_wr_r.data <= data_i;
            end
            // Scalar load wins over a shift, MSB consumed first
            if (wr_en_i && wr_op_sel_i) begin
                key_r <= data_i[ecc_pkg::KEY_SIZE-1:0];
            end else if (req_digit) begin
                key_r <= {key_r[ecc_pkg::KEY_SIZE-2:0], 1'b0};
            end
            // Address reg, RAM read, then output reg
            rd_pipe_r <= {rd_pipe_r[0], rd_reg_i};
            data_r    <= rd_pipe_r[1] ? doutb : '0;
        end
    end

    // Port B belongs to the sequencer while busy
    assign addrb = busy ? uop.addrb : host_wr_r.addr;
    assign web   = busy ? uop.web   : host_wr_r.we;
    assign dinb  = busy ? mult_res  : host_wr_r.data;

    assign data_o = data_r;
    assign busy_o = busy;

    // Host writes only while the engine is idle
    a_no_write_busy: assert property (@(posedge clk) disable iff (!reset_n)
        wr_en_i |-> !busy_o)
        else $error("host write while busy");

endmodule

//--- sim/ecc_tb.sv
/*
 * Directed testbench for the modular arithmetic engine
 * Host port tasks, reference arithmetic, compare tasks
 * and one task per test
 */
`timescale 1ns/1ps

module ecc_tb;

    logic                           clk;
    logic                           reset_n;
    logic [2:0]                     ecc_cmd_i;
    logic [ecc_pkg::ADDR_WIDTH-1:0] addr_i;
    logic                           wr_op_sel_i;
    logic                           wr_en_i;
    logic                           rd_reg_i;
    logic [ecc_pkg::REG_SIZE-1:0]   data_i;
    logic [ecc_pkg::REG_SIZE-1:0]   data_o;
    logic                           busy_o;

    int check_cnt;
    int err_cnt;
    int timeout_cnt;

    ecc_arith_unit ecc_arith_unit_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .ecc_cmd_i   (ecc_cmd_i),
        .addr_i      (addr_i),
        .wr_op_sel_i (wr_op_sel_i),
        .wr_en_i     (wr_en_i),
        .rd_reg_i    (rd_reg_i),
        .data_i      (data_i),
        .data_o      (data_o),
        .busy_o      (busy_o)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    // Reference arithmetic --------------------
    function automatic logic [ecc_pkg::REG_SIZE-1:0] addmod(
        input logic [ecc_pkg::REG_SIZE-1:0] a,
        input logic [ecc_pkg::REG_SIZE-1:0] b,
        input logic [ecc_pkg::REG_SIZE-1:0] m
    );
        logic [63:0] s;
        s = (64'(a) + 64'(b)) % 64'(m);
        return s[ecc_pkg::REG_SIZE-1:0];
    endfunction

    // Operands already below m
    function automatic logic [ecc_pkg::REG_SIZE-1:0] submod(
        input logic [ecc_pkg::REG_SIZE-1:0] a,
        input logic [ecc_pkg::REG_SIZE-1:0] b,
        input logic [ecc_pkg::REG_SIZE-1:0] m
    );
        logic [63:0] s;
        s = (64'(a) + 64'(m) - 64'(b)) % 64'(m);
        return s[ecc_pkg::REG_SIZE-1:0];
    endfunction

    function automatic logic [ecc_pkg::REG_SIZE-1:0] mulmod(
        input logic [ecc_pkg::REG_SIZE-1:0] a,
        input logic [ecc_pkg::REG_SIZE-1:0] b,
        input logic [ecc_pkg::REG_SIZE-1:0] m
    );
        logic [63:0] s;
        s = (64'(a) * 64'(b)) % 64'(m);
        return s[ecc_pkg::REG_SIZE-1:0];
    endfunction

    // Square and multiply, MSB first
    function automatic logic [ecc_pkg::REG_SIZE-1:0] powmod(
        input logic [ecc_pkg::REG_SIZE-1:0] base,
        input logic [ecc_pkg::KEY_SIZE-1:0] key
    );
        logic [ecc_pkg::REG_SIZE-1:0] r;
        logic [ecc_pkg::REG_SIZE-1:0] x;
        r = ecc_pkg::REG_SIZE'(1);
        x = addmod(base, '0, ecc_pkg::P_PRIME);
        for (int i = ecc_pkg::KEY_SIZE - 1; i >= 0; i--) begin
            r = mulmod(r, r, ecc_pkg::P_PRIME);
            if (key[i]) begin
                r = mulmod(r, x, ecc_pkg::P_PRIME);
            end
        end
        return r;
    endfunction

    // Compare tasks --------------------
    task automatic check_word(input string name, input logic [ecc_pkg::REG_SIZE-1:0] exp,
                              input logic [ecc_pkg::REG_SIZE-1:0] act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_busy(input string name, input logic exp, input logic act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s: expected busy %b, actual busy %b", name, exp, act);
        end
    endtask

    // Host port --------------------
    // Inputs change 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input logic [ecc_pkg::ADDR_WIDTH-1:0] addr,
                             input logic [ecc_pkg::REG_SIZE-1:0] value);
        addr_i  = addr;
        data_i  = value;
        wr_en_i = 1'b1;
        next_cycle();
        wr_en_i = 1'b0;
        // RAM write on this edge
        next_cycle();
    endtask

    task automatic load_key(input logic [ecc_pkg::KEY_SIZE-1:0] key);
        data_i      = key;
        wr_op_sel_i = 1'b1;
        wr_en_i     = 1'b1;
        next_cycle();
        wr_en_i     = 1'b0;
        wr_op_sel_i = 1'b0;
    endtask

    // Word valid three edges after the request
    task automatic read_reg(input logic [ecc_pkg::ADDR_WIDTH-1:0] addr,
                            output logic [ecc_pkg::REG_SIZE-1:0] value);
        addr_i   = addr;
        rd_reg_i = 1'b1;
        next_cycle();
        rd_reg_i = 1'b0;
        next_cycle();
        next_cycle();
        value = data_o;
    endtask

    task automatic wait_busy(input logic level, input string what);
        int n;
        n = 0;
        while (busy_o !== level && n < 5000) begin
            next_cycle();
            n++;
        end
        if (busy_o !== level) begin
            timeout_cnt++;
            $display("timeout: busy flag never went to %0d during %s", level, what);
        end
    endtask

    task automatic start_cmd(input ecc_pkg::ecc_cmd_e cmd, input string what);
        ecc_cmd_i = cmd;
        next_cycle();
        ecc_cmd_i = ecc_pkg::CMD_NOP;
        wait_busy(1'b1, what);
    endtask

    task automatic run_cmd(input ecc_pkg::ecc_cmd_e cmd, input string what);
        start_cmd(cmd, what);
        wait_busy(1'b0, what);
    endtask

    // R2 := R0 op R1, then compare
    task automatic single_op(input string name, input ecc_pkg::ecc_cmd_e cmd,
                             input logic [ecc_pkg::REG_SIZE-1:0] a,
                             input logic [ecc_pkg::REG_SIZE-1:0] b,
                             input logic [ecc_pkg::REG_SIZE-1:0] exp);
        logic [ecc_pkg::REG_SIZE-1:0] res;
        write_reg(ecc_pkg::R0_ADDR, a);
        write_reg(ecc_pkg::R1_ADDR, b);
        run_cmd(cmd, name);
        read_reg(ecc_pkg::R2_ADDR, res);
        check_word(name, exp, res);
    endtask

    // Tests --------------------
    task automatic reset_values();
        logic [ecc_pkg::REG_SIZE-1:0] v;
        check_busy("reset", 1'b0, busy_o);
        check_word("reset data_o", '0, data_o);
        read_reg(ecc_pkg::ONE_ADDR, v);
        check_word("reset one word", ecc_pkg::REG_SIZE'(1), v);
        read_reg(ecc_pkg::ZERO_ADDR, v);
        check_word("reset zero word", '0, v);
    endtask

    task automatic write_read_words();
        logic [ecc_pkg::REG_SIZE-1:0] words [6];
        logic [ecc_pkg::REG_SIZE-1:0] v;
        // Odd addresses 1 to 11, constants untouched
        for (int i = 0; i < 6; i++) begin
            words[i] = $urandom;
            write_reg(ecc_pkg::ADDR_WIDTH'(2 * i + 1), words[i]);
        end
        for (int i = 0; i < 6; i++) begin
            read_reg(ecc_pkg::ADDR_WIDTH'(2 * i + 1), v);
            check_word("write_read", words[i], v);
        end
    endtask

    task automatic add_sub_ops();
        logic [ecc_pkg::REG_SIZE-1:0] m;
        logic [ecc_pkg::REG_SIZE-1:0] a;
        logic [ecc_pkg::REG_SIZE-1:0] b;
        for (int k = 0; k < 2; k++) begin
            m = (k == 1) ? ecc_pkg::Q_ORDER : ecc_pkg::P_PRIME;
            for (int i = 0; i < 6; i++) begin
                // First three pairs sit at the edges of the range
                a = (i == 2) ? '0 : m - 1;
                b = (i == 1) ? ecc_pkg::REG_SIZE'(1) : m - 1;
                if (i > 2) begin
                    a = $urandom % m;
                    b = $urandom % m;
                end
                single_op(k ? "add_q" : "add_p", k ? ecc_pkg::CMD_ADD_Q : ecc_pkg::CMD_ADD_P,
                          a, b, addmod(a, b, m));
                single_op(k ? "sub_q" : "sub_p", k ? ecc_pkg::CMD_SUB_Q : ecc_pkg::CMD_SUB_P,
                          a, b, submod(a, b, m));
            end
        end
    endtask

    task automatic mul_ops();
        logic [ecc_pkg::REG_SIZE-1:0] m;
        logic [ecc_pkg::REG_SIZE-1:0] a;
        logic [ecc_pkg::REG_SIZE-1:0] b;
        for (int k = 0; k < 2; k++) begin
            m = (k == 1) ? ecc_pkg::Q_ORDER : ecc_pkg::P_PRIME;
            for (int i = 0; i < 5; i++) begin
                // Full 32-bit words, may exceed the modulus
                a = (i == 0) ? m - 1 : $urandom;
                b = (i == 0) ? m - 1 : $urandom;
                single_op(k ? "mul_q" : "mul_p", k ? ecc_pkg::CMD_MUL_Q : ecc_pkg::CMD_MUL_P,
                          a, b, mulmod(a, b, m));
            end
        end
    endtask

    task automatic ladder_exp();
        logic [ecc_pkg::KEY_SIZE-1:0] keys [4];
        logic [ecc_pkg::REG_SIZE-1:0] base;
        logic [ecc_pkg::REG_SIZE-1:0] res;
        keys[0] = $urandom;
        keys[1] = $urandom;
        keys[2] = '0;
        keys[3] = '1;
        for (int i = 0; i < 4; i++) begin
            base = $urandom;
            write_reg(ecc_pkg::R0_ADDR, base);
            load_key(keys[i]);
            run_cmd(ecc_pkg::CMD_EXP_P, "exp_p");
            read_reg(ecc_pkg::R4_ADDR, res);
            check_word("exp_p", powmod(base, keys[i]), res);
        end
    endtask

    task automatic busy_command_ignored();
        logic [ecc_pkg::REG_SIZE-1:0] a;
        logic [ecc_pkg::REG_SIZE-1:0] b;
        logic [ecc_pkg::REG_SIZE-1:0] res;
        a = $urandom % ecc_pkg::P_PRIME;
        b = $urandom % ecc_pkg::P_PRIME;
        write_reg(ecc_pkg::R0_ADDR, a);
        write_reg(ecc_pkg::R1_ADDR, b);
        start_cmd(ecc_pkg::CMD_ADD_P, "busy_ignore");
        // Second command lands in the first busy cycle
        ecc_cmd_i = ecc_pkg::CMD_MUL_P;
        next_cycle();
        ecc_cmd_i = ecc_pkg::CMD_NOP;
        check_busy("busy_ignore running", 1'b1, busy_o);
        wait_busy(1'b0, "busy_ignore");
        next_cycle();
        next_cycle();
        check_busy("busy_ignore idle", 1'b0, busy_o);
        read_reg(ecc_pkg::R2_ADDR, res);
        check_word("busy_ignore", addmod(a, b, ecc_pkg::P_PRIME), res);
    endtask

    // Main sequence --------------------
    initial begin
        clk         = 1'b0;
        reset_n     = 1'b0;
        ecc_cmd_i   = ecc_pkg::CMD_NOP;
        addr_i      = '0;
        wr_op_sel_i = 1'b0;
        wr_en_i     = 1'b0;
        rd_reg_i    = 1'b0;
        data_i      = '0;
        check_cnt   = 0;
        err_cnt     = 0;
        timeout_cnt = 0;
        void'($urandom(32'h993e_cac4));
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;
        next_cycle();

        reset_values();
        write_read_words();
        add_sub_ops();
        mul_ops();
        ladder_exp();
        busy_command_ignored();

        $display("checks %0d, errors %0d, timeouts %0d", check_cnt, err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
rtl/ecc_pkg.sv
rtl/ecc_ram_tdp_file.sv
rtl/ecc_fau.sv
rtl/ecc_pm_ctrl.sv
rtl/ecc_arith_unit.sv
sim/ecc_tb.sv

//--- Makefile
# Verilator build for the modular arithmetic engine

VERILATOR  ?= verilator
TOP        := ecc_tb
FLIST      := sim.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -Mdir $(OBJ_DIR)
PASS_MSG   := >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
